// File: common/adc_capture_config.svh
`ifndef ADC_CAPTURE_CONFIG_SVH
`define ADC_CAPTURE_CONFIG_SVH

// Bits kept per channel slot and taken MSB first
`define SAMPLE_BITS 24

// Bit counter width inside one LRCK half
// 6 bits covers channel slots of up to 63 bit clocks
`define SLOT_COUNT_BITS 6

// Capture FIFO holds 2**FIFO_DEPTH_LOG2 words
`define FIFO_DEPTH_LOG2 4

`endif

// File: common/adc_capture_pkg.sv
`default_nettype none

`include "adc_capture_config.svh"

package adc_capture_pkg;

    // Command bytes on the control stream
    // Bytes not listed here are ignored by the controller
    typedef enum logic [7:0] {
        CMD_START_RECORDING = 8'h45,
        CMD_STOP_RECORDING  = 8'h46
    } cmd_code_t;

    // One captured channel sample as it travels through the FIFO
    typedef struct packed {
        // High for the right channel (LRCK high half)
        logic                    is_right;
        logic [`SAMPLE_BITS-1:0] data;
    } captured_sample_t;

endpackage

`default_nettype wire

// File: rtl/capture_control.sv
`timescale 1ns/10ps
`default_nettype none

module capture_control (
    input  wire                       adc_pbck,
    input  wire                       reset,
    input  wire                       cmd_valid,
    input  adc_capture_pkg::cmd_code_t cmd_data,
    input  wire                       frame_start,
    input  wire                       sample_strobe,
    input  wire                       fifo_full,
    output logic                      recording,
    output logic                      record_armed,
    output logic                      overflow
);

    import adc_capture_pkg::*;

    // Command level that changes one cycle after the command strobe
    always_ff @(posedge adc_pbck) begin
        if (reset) begin
            recording <= 1'b0;
        end else if (cmd_valid) begin
            case (cmd_data)
                CMD_START_RECORDING: recording <= 1'b1;
                CMD_STOP_RECORDING:  recording <= 1'b0;
                default: ;
            endcase
        end
    end

    // The enable seen by the deserializer only moves at an LRCK falling edge,
    // so every recorded stream starts with a left sample and ends with a right one
    always_ff @(posedge adc_pbck) begin
        if (reset) begin
            record_armed <= 1'b0;
        end else if (frame_start) begin
            record_armed <= recording;
        end
    end

    // Sticky overflow
    // Set when a sample arrives while the FIFO has no room
    always_ff @(posedge adc_pbck) begin
        if (reset) begin
            overflow <= 1'b0;
        end else begin
            if (sample_strobe && fifo_full) begin
                overflow <= 1'b1;
            end
            // A start command wins over a drop in the same cycle
            if (cmd_valid && (cmd_data == CMD_START_RECORDING)) begin
                overflow <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// File: i2s_rx/i2s_deserializer.sv
`timescale 1ns/10ps
`default_nettype none

`include "adc_capture_config.svh"

module i2s_deserializer (
    input  wire                              adc_pbck,
    input  wire                              reset,
    input  wire                              adc_lrck,
    input  wire                              adc_sdata,
    input  wire                              record_armed,
    output logic                             frame_start,
    output logic                             sample_strobe,
    output adc_capture_pkg::captured_sample_t sample
);

    logic                        lrck_last;
    logic                        lrck_edge;
    logic [`SLOT_COUNT_BITS-1:0] bit_count;
    logic [`SAMPLE_BITS-1:0]     shift_reg;

    // Edge seen when the sampled LRCK differs from the previous sample
    assign lrck_edge = adc_lrck ^ lrck_last;

    // Falling edge opens a new frame (left half first)
    assign frame_start = lrck_last & ~adc_lrck;

    always_ff @(posedge adc_pbck) begin
        if (reset) begin
            lrck_last <= 1'b0;
        end else begin
            lrck_last <= adc_lrck;
        end
    end

    // Bit position within the current half
    // Starts saturated so nothing is shifted before the first edge
    always_ff @(posedge adc_pbck) begin
        if (reset) begin
            bit_count <= '1;
        end else if (lrck_edge) begin
            bit_count <= '0;
        end else if (bit_count != '1) begin
            bit_count <= bit_count + 1'b1;
        end
    end

    // MSB arrives one bit clock after the LRCK change
    // Bits past SAMPLE_BITS are junk and are not shifted in
    always_ff @(posedge adc_pbck) begin
        if (lrck_edge) begin
            shift_reg <= '0;
        end else if (bit_count < `SAMPLE_BITS) begin
            shift_reg <= {shift_reg[`SAMPLE_BITS-2:0], adc_sdata};
        end
    end

    // Hand out the half that has just ended
    // lrck_last still holds the level of that half
    always_ff @(posedge adc_pbck) begin
        if (lrck_edge) begin
            sample.is_right <= lrck_last;
            sample.data     <= shift_reg;
        end
    end

    // record_armed has not moved yet at the falling edge that closes a frame,
    // so the right sample follows the same enable as its left sample
    always_ff @(posedge adc_pbck) begin
        if (reset) begin
            sample_strobe <= 1'b0;
        end else begin
            sample_strobe <= lrck_edge & record_armed;
        end
    end

endmodule

`default_nettype wire

// File: i2s_rx/sample_fifo.sv
`timescale 1ns/10ps
`default_nettype none

module sample_fifo #(
    parameter int depth_log2 = 4
) (
    input  wire                              adc_pbck,
    input  wire                              reset,
    input  wire                              wr_strobe,
    input  adc_capture_pkg::captured_sample_t wr_data,
    input  wire                              rd_ready,
    output logic                             rd_valid,
    output adc_capture_pkg::captured_sample_t rd_data,
    output logic                             full
);

    import adc_capture_pkg::*;

    localparam int depth = 1 << depth_log2;

    captured_sample_t      mem [depth];
    logic [depth_log2-1:0] wr_ptr;
    logic [depth_log2-1:0] rd_ptr;
    logic [depth_log2:0]   count;
    logic                  wr_en;
    logic                  rd_en;

    assign full     = (count == (depth_log2 + 1)'(depth));
    assign rd_valid = (count != '0);
    assign rd_data  = mem[rd_ptr];

    // Samples come in real time so a write into a full buffer is simply lost
    assign wr_en = wr_strobe & ~full;
    assign rd_en = rd_valid & rd_ready;

    always_ff @(posedge adc_pbck) begin
        if (wr_en) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    // Pointers wrap naturally at the power-of-two depth
    always_ff @(posedge adc_pbck) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    // Occupancy stays unchanged on a simultaneous read and write
    always_ff @(posedge adc_pbck) begin
        if (reset) begin
            count <= '0;
        end else begin
            case ({wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: ;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: rtl/adc_capture_top.sv
`timescale 1ns/10ps
`default_nettype none

`include "adc_capture_config.svh"

module adc_capture_top (
    input  wire                              adc_pbck,
    input  wire                              reset,
    input  wire                              cmd_valid,
    input  adc_capture_pkg::cmd_code_t        cmd_data,
    input  wire                              adc_lrck,
    input  wire                              adc_sdata,
    input  wire                              sample_ready,
    output logic                             sample_valid,
    output adc_capture_pkg::captured_sample_t sample,
    output logic                             recording,
    output logic                             overflow
);

    import adc_capture_pkg::*;

    logic             frame_start;
    logic             record_armed;
    logic             sample_strobe;
    logic             fifo_full;
    captured_sample_t rx_sample;

    capture_control ctrl0 (
        .adc_pbck     (adc_pbck),
        .reset        (reset),
        .cmd_valid    (cmd_valid),
        .cmd_data     (cmd_data),
        .frame_start  (frame_start),
        .sample_strobe(sample_strobe),
        .fifo_full    (fifo_full),
        .recording    (recording),
        .record_armed (record_armed),
        .overflow     (overflow)
    );

    i2s_deserializer rx0 (
        .adc_pbck     (adc_pbck),
        .reset        (reset),
        .adc_lrck     (adc_lrck),
        .adc_sdata    (adc_sdata),
        .record_armed (record_armed),
        .frame_start  (frame_start),
        .sample_strobe(sample_strobe),
        .sample       (rx_sample)
    );

    sample_fifo #(
        .depth_log2(`FIFO_DEPTH_LOG2)
    ) fifo0 (
        .adc_pbck (adc_pbck),
        .reset    (reset),
        .wr_strobe(sample_strobe),
        .wr_data  (rx_sample),
        .rd_ready (sample_ready),
        .rd_valid (sample_valid),
        .rd_data  (sample),
        .full     (fifo_full)
    );

endmodule

`default_nettype wire

// File: tests/tb_adc_capture.sv
`timescale 1ns/10ps
`default_nettype none

`include "adc_capture_config.svh"

module tb_adc_capture;

    import adc_capture_pkg::*;

    localparam int CLK_PERIOD  = 20;
    localparam int SLOT_CLOCKS = 32;
    localparam int FIFO_WORDS  = 1 << `FIFO_DEPTH_LOG2;
    localparam int ACT_NONE    = 0;
    localparam int ACT_CMD     = 1;
    localparam int ACT_RESET   = 2;

    logic             adc_pbck;
    logic             reset;
    logic             cmd_valid;
    cmd_code_t        cmd_data;
    logic             adc_lrck;
    logic             adc_sdata;
    logic             sample_ready;
    logic             sample_valid;
    captured_sample_t sample;
    logic             recording;
    logic             overflow;

    // Stimulus table with one entry per row
    string     row_name[$];
    int        row_action[$];
    cmd_code_t row_cmd[$];
    int        row_frames[$];
    logic      row_ready[$];
    logic      row_exp_recording[$];
    logic      row_exp_overflow[$];

    // Reference model of the FIFO contents and the control levels
    captured_sample_t expected_words[$];
    logic             model_recording;
    logic             model_overflow;
    logic [15:0]      lfsr;
    logic             prev_lsb;
    string            current_test;
    int               total_frames   = 0;
    int               check_count    = 0;
    int               mismatch_count = 0;
    int               failure_count  = 0;
    bit               table_ready    = 1'b0;

    adc_capture_top dut0 (
        .adc_pbck    (adc_pbck),
        .reset       (reset),
        .cmd_valid   (cmd_valid),
        .cmd_data    (cmd_data),
        .adc_lrck    (adc_lrck),
        .adc_sdata   (adc_sdata),
        .sample_ready(sample_ready),
        .sample_valid(sample_valid),
        .sample      (sample),
        .recording   (recording),
        .overflow    (overflow)
    );

    initial begin
        adc_pbck = 1'b0;
        forever begin
            #(CLK_PERIOD / 2);
            adc_pbck = ~adc_pbck;
        end
    end

    // 16-bit Fibonacci LFSR with taps 16 14 13 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] state);
        logic feedback;
        feedback = state[15] ^ state[13] ^ state[12] ^ state[10];
        return {state[14:0], feedback};
    endfunction

    task automatic add_row(input string name, input int action, input cmd_code_t cmd,
                           input int frames, input logic ready,
                           input logic exp_recording, input logic exp_overflow);
        row_name.push_back(name);
        row_action.push_back(action);
        row_cmd.push_back(cmd);
        row_frames.push_back(frames);
        row_ready.push_back(ready);
        row_exp_recording.push_back(exp_recording);
        row_exp_overflow.push_back(exp_overflow);
        total_frames += frames;
    endtask

    task automatic load_table();
        //      name            action     command              frames ready rec   ovf
        add_row("idle",         ACT_NONE,  cmd_code_t'(8'h00),  3,     1'b1, 1'b0, 1'b0);
        add_row("start",        ACT_CMD,   CMD_START_RECORDING, 4,     1'b1, 1'b1, 1'b0);
        add_row("junk_bits",    ACT_NONE,  cmd_code_t'(8'h00),  2,     1'b1, 1'b1, 1'b0);
        add_row("stop",         ACT_CMD,   CMD_STOP_RECORDING,  3,     1'b1, 1'b0, 1'b0);
        add_row("stall",        ACT_CMD,   CMD_START_RECORDING, 12,    1'b0, 1'b1, 1'b1);
        add_row("drain",        ACT_NONE,  cmd_code_t'(8'h00),  3,     1'b1, 1'b1, 1'b1);
        add_row("clear",        ACT_CMD,   CMD_START_RECORDING, 2,     1'b0, 1'b1, 1'b0);
        add_row("mid_reset",    ACT_RESET, cmd_code_t'(8'h00),  2,     1'b1, 1'b0, 1'b0);
        add_row("after_reset",  ACT_CMD,   CMD_START_RECORDING, 2,     1'b1, 1'b1, 1'b0);
        add_row("ignored_byte", ACT_CMD,   cmd_code_t'(8'h5a),  2,     1'b1, 1'b1, 1'b0);
        add_row("tail",         ACT_CMD,   CMD_STOP_RECORDING,  2,     1'b1, 1'b0, 1'b0);
    endtask

    // First bit taken ends up as the MSB of the slot
    task automatic next_slot_word(output logic [31:0] word);
        word = '0;
        for (int i = 0; i < SLOT_CLOCKS; i++) begin
            lfsr = lfsr_next(lfsr);
            word = {word[30:0], lfsr[0]};
        end
    endtask

    // A full FIFO loses the new sample and raises the overflow flag
    task automatic store_expected(input logic is_right, input logic [`SAMPLE_BITS-1:0] data);
        captured_sample_t word;
        word.is_right = is_right;
        word.data     = data;
        if (expected_words.size() < FIFO_WORDS) begin
            expected_words.push_back(word);
        end else begin
            model_overflow = 1'b1;
        end
    endtask

    // Commands and resets land in the middle of the left slot
    // Ready changes a bit later
    task automatic apply_row_action(input int row, input int k, inout logic frame_armed);
        if (k == 4 && row_action[row] == ACT_CMD) begin
            cmd_valid = 1'b1;
            cmd_data  = row_cmd[row];
            if (row_cmd[row] == CMD_START_RECORDING) begin
                model_recording = 1'b1;
                model_overflow  = 1'b0;
            end else if (row_cmd[row] == CMD_STOP_RECORDING) begin
                model_recording = 1'b0;
            end
        end
        if (row_action[row] == ACT_RESET) begin
            if (k == 4) begin
                reset = 1'b1;
                expected_words.delete();
                model_recording = 1'b0;
                model_overflow  = 1'b0;
                frame_armed     = 1'b0;
            end else if (k == 12) begin
                reset = 1'b0;
            end
        end
        if (k == 8) begin
            sample_ready = row_ready[row];
        end
    endtask

    // One frame with the left slot and then the right slot
    task automatic drive_frame(input int row, input bit first_frame);
        logic [31:0] word;
        logic [31:0] shifter;
        logic        frame_armed;
        frame_armed = model_recording;
        for (int half = 0; half < 2; half++) begin
            next_slot_word(word);
            shifter = word;
            for (int k = 0; k < SLOT_CLOCKS; k++) begin
                @(negedge adc_pbck);
                cmd_valid = 1'b0;
                if (k == 0) begin
                    // LRCK moves one bit clock ahead of the MSB
                    adc_lrck  = (half == 1);
                    adc_sdata = prev_lsb;
                end else begin
                    adc_sdata = shifter[31];
                    shifter   = {shifter[30:0], 1'b0};
                end
                if (first_frame && half == 0) begin
                    apply_row_action(row, k, frame_armed);
                end
            end
            // Last slot bit spills into the first clock of the next slot
            prev_lsb = word[0];
            if (frame_armed) begin
                store_expected(half == 1, word[31 -: `SAMPLE_BITS]);
            end
        end
    endtask

    task automatic check_levels(input int row);
        check_count += 3;
        assert (recording == row_exp_recording[row]) else begin
            $display("Mismatch in %s: recording expected %b, actual %b",
                     row_name[row], row_exp_recording[row], recording);
            mismatch_count++;
        end
        assert (overflow == row_exp_overflow[row]) else begin
            $display("Mismatch in %s: overflow expected %b, actual %b",
                     row_name[row], row_exp_overflow[row], overflow);
            mismatch_count++;
        end
        assert (overflow == model_overflow) else begin
            $display("Mismatch in %s: overflow expected %b by the reference model, actual %b",
                     row_name[row], model_overflow, overflow);
            mismatch_count++;
        end
    endtask

    task automatic finish_run();
        $display("Checks: %0d, mismatches: %0d, other errors: %0d",
                 check_count, mismatch_count, failure_count);
        if (mismatch_count == 0 && failure_count == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    endtask

    // Every word offered must be the oldest one in the model
    always @(posedge adc_pbck) begin
        if (!reset && sample_valid) begin
            assert (expected_words.size() != 0) else begin
                $display("Error in %s: the FIFO offers a word that was never recorded",
                         current_test);
                failure_count++;
            end
            if (sample_ready && expected_words.size() != 0) begin
                check_count++;
                assert (sample == expected_words[0]) else begin
                    $display("Mismatch in %s: expected %h, actual %h",
                             current_test, expected_words[0], sample);
                    mismatch_count++;
                end
                expected_words.delete(0);
            end
        end
    end

    initial begin
        wait (table_ready);
        #(2 * total_frames * 2 * SLOT_CLOCKS * CLK_PERIOD);
        $display("Timeout: the run did not end within twice the length of the table");
        failure_count++;
        finish_run();
    end

    initial begin
        reset           = 1'b1;
        cmd_valid       = 1'b0;
        cmd_data        = CMD_STOP_RECORDING;
        adc_lrck        = 1'b1;
        adc_sdata       = 1'b0;
        sample_ready    = 1'b1;
        lfsr            = 16'd2;
        prev_lsb        = 1'b0;
        model_recording = 1'b0;
        model_overflow  = 1'b0;
        current_test    = "reset";
        load_table();
        table_ready = 1'b1;
        repeat (8) @(posedge adc_pbck);
        @(negedge adc_pbck);
        reset = 1'b0;
        for (int row = 0; row < row_name.size(); row++) begin
            current_test = row_name[row];
            for (int f = 0; f < row_frames[row]; f++) begin
                drive_frame(row, f == 0);
            end
            check_levels(row);
        end
        repeat (4) @(negedge adc_pbck);
        assert (expected_words.size() == 0 && !sample_valid) else begin
            $display("Error at end of run: recorded words were not delivered as expected");
            failure_count++;
        end
        finish_run();
    end

endmodule

`default_nettype wire

// File: sources.f
+incdir+common
common/adc_capture_pkg.sv
rtl/capture_control.sv
i2s_rx/i2s_deserializer.sv
i2s_rx/sample_fifo.sv
rtl/adc_capture_top.sv
tests/tb_adc_capture.sv

// File: run_sim.sh
#!/bin/sh
# Builds the testbench with Verilator, runs it and looks for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timescale 1ns/10ps \
    --top-module tb_adc_capture -f sources.f \
    && ./obj_dir/Vtb_adc_capture | tee /dev/stderr | grep -x '>>> PASS' > /dev/null \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }
